/* common/cart_pkg.sv */
package cart_pkg;

	// ===================================================================
	// Stream widths
	// ===================================================================

	typedef logic [15:0] halfword_t;   // One download word, little endian
	typedef logic [63:0] qword_t;      // Four halfwords, halfword 0 in the low bits
	typedef logic [26:0] rom_addr_t;   // Byte address, 128 MB cartridge space
	typedef logic [2:0]  lane_count_t; // Valid halfwords in a beat, 1 to 4

	// ===================================================================
	// Compatibility quirks
	// ===================================================================

	typedef logic [5:0] quirk_t;

	// Game probes SRAM to detect emulation, so SRAM has to look absent
	localparam int QUIRK_SRAM   = 0;
	// Game relies on mirrored ROM accesses
	localparam int QUIRK_REMAP  = 1;
	localparam int QUIRK_GPIO   = 2;   // GPIO lines for RTC or solar sensor
	localparam int QUIRK_TILT   = 3;   // Tilt sensor on the cartridge bus
	localparam int QUIRK_SOLAR  = 4;   // Solar sensor fitted
	// Game needs the full sprite pixel budget per line
	localparam int QUIRK_SPRITE = 5;

	// ===================================================================
	// ROM header and image markers
	// ===================================================================

	// Four character game code, first character at the lowest address
	localparam rom_addr_t HDR_CODE_ADDR   = 27'h00000AC;

	// First halfword after the game code, quirks are decided here
	localparam rom_addr_t HDR_DECIDE_ADDR = 27'h00000B0;

	// Save type string of 128 KB flash carts, may sit anywhere in the image
	localparam logic [71:0] FLASH_MARKER = "FLASH1M_V";

endpackage

/* common/rom_stream_if.sv */
`timescale 1ns/1ps

// Quadword beats of the cartridge image, valid/ready handshake
interface rom_stream_if import cart_pkg::*; ();

	logic        valid;
	logic        ready;
	qword_t      data;
	rom_addr_t   addr;   // Byte address of halfword 0
	lane_count_t count;
	logic        last;   // Beat holds the final halfword of the image

	modport source (
		output valid, data, addr, count, last,
		input  ready
	);

	modport sink (
		input  valid, data, addr, count, last,
		output ready
	);

endinterface

/* verilog/halfword_packer.sv */
`timescale 1ns/1ps

module halfword_packer import cart_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset,
	input  logic      dl_valid,
	output logic      dl_ready,
	input  halfword_t dl_data,
	input  logic      dl_last,
	rom_stream_if.source out
);

	logic [1:0] lane;       // Next lane to fill
	qword_t     acc;        // Lanes collected so far
	rom_addr_t  base_addr;  // Byte address of lane 0 of the beat being built
	qword_t     beat_data;
	logic       accept;
	logic       emit;

	// Output register frees up in the cycle its beat is taken
	assign dl_ready = !out.valid || out.ready;
	assign accept   = dl_valid && dl_ready;
	assign emit     = accept && (lane == 2'd3 || dl_last);

	// Current halfword merged into the collected lanes
	always_comb begin
		beat_data = acc;
		beat_data[{lane, 4'b0000} +: 16] = dl_data;
	end

	// ===================================================================
	// Lane and address tracking
	// ===================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			lane      <= 2'd0;
			base_addr <= '0;
			out.valid <= 1'b0;
		end else begin
			if (out.valid && out.ready)
				out.valid <= 1'b0;

			if (emit) begin
				out.valid <= 1'b1;
				lane      <= 2'd0;
				// Next image starts again at byte 0
				base_addr <= dl_last ? '0 : base_addr + rom_addr_t'(8);
			end else if (accept) begin
				lane <= lane + 2'd1;
			end
		end
	end

	// Beat payload
	always_ff @(posedge clk_sys) begin
		if (accept)
			acc[{lane, 4'b0000} +: 16] <= dl_data;

		if (emit) begin
			out.data  <= beat_data;
			out.addr  <= base_addr;
			out.count <= {1'b0, lane} + 3'd1;   // Lanes filled including this one
			out.last  <= dl_last;
		end
	end

endmodule

/* verilog/rom_fifo.sv */
`timescale 1ns/1ps

module rom_fifo import cart_pkg::*; #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic clk_sys,
	input  logic reset,
	rom_stream_if.sink   wr,
	rom_stream_if.source rd
);

	localparam int PTR_W  = $clog2(FIFO_DEPTH);
	localparam int FILL_W = PTR_W + 1;

	qword_t      data_mem  [0:FIFO_DEPTH-1];
	rom_addr_t   addr_mem  [0:FIFO_DEPTH-1];
	lane_count_t count_mem [0:FIFO_DEPTH-1];
	logic        last_mem  [0:FIFO_DEPTH-1];

	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [FILL_W-1:0] fill;    // Beats currently stored
	logic              push;
	logic              pop;

	assign wr.ready = (fill != FILL_W'(FIFO_DEPTH));
	assign rd.valid = (fill != '0);
	assign push     = wr.valid && wr.ready;
	assign pop      = rd.valid && rd.ready;

	// Head of the queue, read straight from storage
	assign rd.data  = data_mem[rd_ptr];
	assign rd.addr  = addr_mem[rd_ptr];
	assign rd.count = count_mem[rd_ptr];
	assign rd.last  = last_mem[rd_ptr];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;   // Depth is a power of two, pointers wrap
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;

			case ({push, pop})
				2'b10:   fill <= fill + 1'b1;
				2'b01:   fill <= fill - 1'b1;
				default: fill <= fill;     // Both or neither
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (push) begin
			data_mem[wr_ptr]  <= wr.data;
			addr_mem[wr_ptr]  <= wr.addr;
			count_mem[wr_ptr] <= wr.count;
			last_mem[wr_ptr]  <= wr.last;
		end
	end

endmodule

/* cart_scan/cart_scan.sv */
`timescale 1ns/1ps

module cart_scan import cart_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset,
	rom_stream_if.sink in,
	output quirk_t    quirks,
	output logic      flash_1m,
	output logic      cart_loaded,
	output rom_addr_t rom_size
);

	typedef enum logic {
		S_IDLE,
		S_UNPACK
	} state_t;

	state_t      state;
	qword_t      beat_data;    // Remaining halfwords, current one in the low bits
	rom_addr_t   hw_addr;      // Byte address of the current halfword
	lane_count_t hw_left;
	logic        beat_last;
	logic [31:0] game_code;    // First character in the top byte
	logic [63:0] history;      // Last eight bytes in stream order
	halfword_t   hw;
	logic        take_beat;
	logic        start_image;
	logic        marker_lo;
	logic        marker_hi;
	logic        final_hw;

	// Flags for the known titles and title families
	function automatic quirk_t decide_quirks(input logic [31:0] code);
		quirk_t q;
		q = '0;

		case (code[31:8])
			"AR8", "ARO", "ALG", "ALF", "BLF",
			"BDB", "BG3", "BDV", "A2Y", "AI2": q[QUIRK_SRAM] = 1'b1;
			"BPE", "AXV", "AXP", "RZW", "BKA",
			"BR4":                             q[QUIRK_GPIO] = 1'b1;
			"BHG", "BGX":                      q[QUIRK_SPRITE] = 1'b1;
			default: ;
		endcase

		case (code[31:24])
			"K": q[QUIRK_TILT] = 1'b1;   // Tilt sensor titles
			"U": begin                   // Solar sensor titles
				q[QUIRK_GPIO]  = 1'b1;
				q[QUIRK_SOLAR] = 1'b1;
			end
			"F": begin                   // NES classic re-releases
				q[QUIRK_SRAM]  = 1'b1;
				q[QUIRK_REMAP] = 1'b1;
				case (code)
					"FSDJ", "FADJ", "FM2J": q[QUIRK_SPRITE] = 1'b1;
					"FTUJ", "FTKJ", "FFMJ", "FLBJ",
					"FPTJ", "FMRJ", "FNMJ": begin
						q[QUIRK_REMAP]  = 1'b0;
						q[QUIRK_SPRITE] = 1'b1;
					end
					default: ;
				endcase
			end
			default: ;
		endcase

		return q;
	endfunction

	assign in.ready    = (state == S_IDLE);
	assign take_beat   = in.valid && in.ready;
	assign start_image = take_beat && (in.addr == '0);
	assign hw          = beat_data[15:0];
	assign final_hw    = beat_last && (hw_left == 3'd1);

	// Marker ending at the low byte or at the high byte of this halfword
	assign marker_lo = ({history, hw[7:0]} == FLASH_MARKER);
	assign marker_hi = ({history[55:0], hw[7:0], hw[15:8]} == FLASH_MARKER);

	// ===================================================================
	// FSM and results
	// ===================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state       <= S_IDLE;
			quirks      <= '0;
			flash_1m    <= 1'b0;
			cart_loaded <= 1'b0;
			rom_size    <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (take_beat)
						state <= S_UNPACK;
				end
				S_UNPACK: begin
					if (hw_left == 3'd1)
						state <= S_IDLE;
					if (hw_addr == HDR_DECIDE_ADDR)
						quirks <= decide_quirks(game_code);
					if (marker_lo || marker_hi)
						flash_1m <= 1'b1;
					if (final_hw) begin
						rom_size    <= hw_addr + rom_addr_t'(2);   // Byte after the image
						cart_loaded <= 1'b1;
					end
				end
			endcase

			if (start_image) begin   // New image from byte 0
				quirks      <= '0;
				flash_1m    <= 1'b0;
				cart_loaded <= 1'b0;
			end
		end
	end

	// ===================================================================
	// Halfword unpacking, header and history capture
	// ===================================================================

	always_ff @(posedge clk_sys) begin
		if (take_beat) begin
			beat_data <= in.data;
			hw_addr   <= in.addr;
			hw_left   <= in.count;
			beat_last <= in.last;
			if (in.addr == '0) begin
				game_code <= '0;
				history   <= '0;
			end
		end else if (state == S_UNPACK) begin
			beat_data <= {16'h0000, beat_data[63:16]};
			hw_addr   <= hw_addr + rom_addr_t'(2);
			hw_left   <= hw_left - 3'd1;
			history   <= {history[47:0], hw[7:0], hw[15:8]};

			// Byte at the lower address goes higher in the code
			if (hw_addr == HDR_CODE_ADDR)
				game_code[31:16] <= {hw[7:0], hw[15:8]};
			if (hw_addr == HDR_CODE_ADDR + rom_addr_t'(2))
				game_code[15:0] <= {hw[7:0], hw[15:8]};
		end
	end

endmodule

/* verilog/cart_loader.sv */
`timescale 1ns/1ps

module cart_loader import cart_pkg::*; #(
	parameter int FIFO_DEPTH = 4   // Power of two, at least 2
) (
	input  logic      clk_sys,
	input  logic      reset,
	input  logic      dl_valid,
	output logic      dl_ready,
	input  halfword_t dl_data,
	input  logic      dl_last,
	output logic      sram_quirk,
	output logic      memory_remap_quirk,
	output logic      gpio_quirk,
	output logic      tilt_quirk,
	output logic      solar_quirk,
	output logic      sprite_quirk,
	output logic      flash_1m,
	output logic      cart_loaded,
	output rom_addr_t rom_size
);

	quirk_t quirks;

	rom_stream_if pack_stream ();   // Packer to FIFO
	rom_stream_if scan_stream ();   // FIFO to scanner

	halfword_packer packer_i (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.dl_valid (dl_valid),
		.dl_ready (dl_ready),
		.dl_data  (dl_data),
		.dl_last  (dl_last),
		.out      (pack_stream.source)
	);

	rom_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) fifo_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.wr      (pack_stream.sink),
		.rd      (scan_stream.source)
	);

	cart_scan scan_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.in          (scan_stream.sink),
		.quirks      (quirks),
		.flash_1m    (flash_1m),
		.cart_loaded (cart_loaded),
		.rom_size    (rom_size)
	);

	// Individual flags for the console core
	assign sram_quirk         = quirks[QUIRK_SRAM];
	assign memory_remap_quirk = quirks[QUIRK_REMAP];
	assign gpio_quirk         = quirks[QUIRK_GPIO];
	assign tilt_quirk         = quirks[QUIRK_TILT];
	assign solar_quirk        = quirks[QUIRK_SOLAR];
	assign sprite_quirk       = quirks[QUIRK_SPRITE];

endmodule

/* bench/tb_cases.svh */
`ifndef TB_CASES_SVH
`define TB_CASES_SVH

// One cartridge image per entry, loaded back to back without a reset in between
typedef struct packed {
	logic [31:0] code;     // Game code, first character in the top byte
	logic [15:0] len;      // Image length in halfwords
	logic [15:0] marker;   // Byte offset of the flash marker
	logic [5:0]  quirks;   // Expected flags, SPRITE down to SRAM
	logic        flash;    // Expected flash_1m
} test_case_t;

localparam logic [15:0] NO_MARKER = 16'hFFFF;
localparam int NUM_CASES = 14;

localparam test_case_t CASES [0:NUM_CASES-1] = '{
	'{"BPEE", 16'd301,  NO_MARKER, F_GPIO,                     1'b0},
	'{"AR8E", 16'd262,  NO_MARKER, F_SRAM,                     1'b0},
	'{"BHGE", 16'd259,  16'h0040,  F_SPRITE,                   1'b1},   // Even offset
	'{"KXYE", 16'd333,  NO_MARKER, F_TILT,                     1'b0},
	'{"UZZE", 16'd301,  16'h01F5,  F_GPIO | F_SOLAR,           1'b1},   // Odd, across beats
	'{"ZQXE", 16'd250,  NO_MARKER, 6'b000000,                  1'b0},   // Unknown title
	'{"FZZJ", 16'd277,  16'h00C3,  F_SRAM | F_REMAP,           1'b1},
	'{"FTUJ", 16'd290,  NO_MARKER, F_SRAM | F_SPRITE,          1'b0},
	'{"FSDJ", 16'd515,  16'h002E,  F_SRAM | F_REMAP | F_SPRITE, 1'b1},
	// Header code present but the image ends before 0xB2
	'{"AR8E", 16'h0058, NO_MARKER, 6'b000000,                  1'b0},
	'{"BPEE", 16'h0059, NO_MARKER, F_GPIO,                     1'b0},   // Just long enough
	'{"AR8E", 16'd258,  16'h01FB,  F_SRAM,                     1'b1},   // Marker at the end
	'{"FNMJ", 16'h0100, NO_MARKER, F_SRAM | F_SPRITE,          1'b0},
	'{"BGXE", 16'd300,  NO_MARKER, F_SPRITE,                   1'b0}
};

`endif

/* bench/tb_cart_loader.sv */
`timescale 1ns/1ps

module tb_cart_loader;

	localparam int MAX_BYTES  = 2048;
	localparam int WAIT_LIMIT = 200;    // Cycles with dl_ready low for one halfword
	localparam int LOAD_LIMIT = 2000;   // Cycles from the last halfword to cart_loaded
	localparam int CODE_ADDR  = 172;    // 0xAC

	// Flag masks in the order {sprite, solar, tilt, gpio, remap, sram}
	localparam logic [5:0] F_SRAM   = 6'b000001;
	localparam logic [5:0] F_REMAP  = 6'b000010;
	localparam logic [5:0] F_GPIO   = 6'b000100;
	localparam logic [5:0] F_TILT   = 6'b001000;
	localparam logic [5:0] F_SOLAR  = 6'b010000;
	localparam logic [5:0] F_SPRITE = 6'b100000;

	localparam logic [71:0] MARKER = "FLASH1M_V";

`include "tb_cases.svh"

	logic        clk_sys;
	logic        reset;
	logic        dl_valid;
	logic        dl_ready;
	logic [15:0] dl_data;
	logic        dl_last;
	logic        sram_quirk;
	logic        memory_remap_quirk;
	logic        gpio_quirk;
	logic        tilt_quirk;
	logic        solar_quirk;
	logic        sprite_quirk;
	logic        flash_1m;
	logic        cart_loaded;
	logic [26:0] rom_size;

	logic [7:0]  img [0:MAX_BYTES-1];
	integer      seed;
	int          stall_cycles;   // Cycles the DUT held off a pending halfword
	logic        load_cleared;   // cart_loaded seen low since the image started

	cart_loader #(
		.FIFO_DEPTH (4)
	) cart_loader_i (
		.clk_sys            (clk_sys),
		.reset              (reset),
		.dl_valid           (dl_valid),
		.dl_ready           (dl_ready),
		.dl_data            (dl_data),
		.dl_last            (dl_last),
		.sram_quirk         (sram_quirk),
		.memory_remap_quirk (memory_remap_quirk),
		.gpio_quirk         (gpio_quirk),
		.tilt_quirk         (tilt_quirk),
		.solar_quirk        (solar_quirk),
		.sprite_quirk       (sprite_quirk),
		.flash_1m           (flash_1m),
		.cart_loaded        (cart_loaded),
		.rom_size           (rom_size)
	);

	always #2 clk_sys = ~clk_sys;

	// ===================================================================
	// Checks
	// ===================================================================

	function automatic logic [5:0] observed_quirks();
		return {sprite_quirk, solar_quirk, tilt_quirk, gpio_quirk, memory_remap_quirk,
			sram_quirk};
	endfunction

	task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
		input string what);
		if (got !== expected) begin
			$display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
			$display("Test FAILED");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout while waiting for %s", what);
		$display("Test FAILED");
		$fatal(1, "Simulation stopped after a timeout");
	endtask

	// Flags must drop as soon as the scanner starts a new image
	task automatic watch_load_state();
		if (!cart_loaded && !load_cleared) begin
			load_cleared = 1'b1;
			check_value(32'(observed_quirks()), 32'd0, "quirks at image start");
			check_value(32'(flash_1m), 32'd0, "flash_1m at image start");
		end
	endtask

	// ===================================================================
	// Stimulus
	// ===================================================================

	task automatic build_image(input test_case_t tc);
		logic [31:0] r;
		int nbytes;
		int mk;
		nbytes = 2 * int'(tc.len);
		mk     = int'(tc.marker);
		for (int i = 0; i < nbytes; i++) begin
			r      = $random(seed);
			img[i] = 8'h61 + 8'(r % 32'd26);   // Lowercase filler only
		end
		for (int k = 0; k < 4; k++)
			if (CODE_ADDR + k < nbytes)
				img[CODE_ADDR + k] = tc.code[31 - 8*k -: 8];
		if (tc.marker != NO_MARKER) begin
			for (int k = 0; k < 9; k++)
				if (mk + k < nbytes)
					img[mk + k] = MARKER[71 - 8*k -: 8];
		end
	endtask

	task automatic idle_cycles(input int n);
		for (int i = 0; i < n; i++) begin
			@(negedge clk_sys);
			dl_valid = 1'b0;
			dl_last  = 1'b0;
			watch_load_state();
		end
	endtask

	// Present one halfword and hold it until dl_ready is high before the next edge
	task automatic drive_halfword(input logic [15:0] data, input logic last);
		int waited;
		waited = 0;
		@(negedge clk_sys);
		dl_valid = 1'b1;
		dl_data  = data;
		dl_last  = last;
		watch_load_state();
		while (!dl_ready) begin
			stall_cycles++;
			waited++;
			if (waited > WAIT_LIMIT)
				report_timeout("dl_ready to go high");
			@(negedge clk_sys);
			watch_load_state();
		end
	endtask

	task automatic send_image(input int len);
		logic [31:0] r;
		load_cleared = 1'b0;
		for (int h = 0; h < len; h++) begin
			r = $random(seed);
			if (r[4:0] == 5'd0)
				idle_cycles(int'(r[6:5]) + 1);   // Random gap in dl_valid
			drive_halfword({img[2*h + 1], img[2*h]}, h == len - 1);
		end
		idle_cycles(1);
	endtask

	task automatic wait_loaded();
		int waited;
		waited = 0;
		while (!(load_cleared && cart_loaded)) begin
			waited++;
			if (waited > LOAD_LIMIT)
				report_timeout("cart_loaded after the last halfword");
			@(negedge clk_sys);
			watch_load_state();
		end
	endtask

	// ===================================================================
	// Main sequence
	// ===================================================================

	initial begin
		seed         = 32'hd6e0_2ca2;
		stall_cycles = 0;
		load_cleared = 1'b0;
		clk_sys      = 1'b0;
		reset        = 1'b1;
		dl_valid     = 1'b0;
		dl_data      = 16'h0000;
		dl_last      = 1'b0;

		repeat (4) @(negedge clk_sys);
		reset = 1'b0;

		check_value(32'(dl_ready), 32'd1, "dl_ready after reset");
		check_value(32'(cart_loaded), 32'd0, "cart_loaded after reset");
		check_value(32'(flash_1m), 32'd0, "flash_1m after reset");
		check_value(32'(observed_quirks()), 32'd0, "quirks after reset");
		check_value(32'(rom_size), 32'd0, "rom_size after reset");

		for (int n = 0; n < NUM_CASES; n++) begin
			build_image(CASES[n]);
			send_image(int'(CASES[n].len));
			wait_loaded();
			check_value(32'(rom_size), 32'(2 * int'(CASES[n].len)),
				$sformatf("case %0d rom_size", n));
			check_value(32'(observed_quirks()), 32'(CASES[n].quirks),
				$sformatf("case %0d quirks", n));
			check_value(32'(flash_1m), 32'(CASES[n].flash),
				$sformatf("case %0d flash_1m", n));
		end

		// Scanner is slower than the download, so the FIFO must have filled
		check_value(32'(stall_cycles > 0), 32'd1, "back-pressure on dl_ready");

		$display("Test OK");
		$finish;
	end

endmodule

/* files.f */
common/cart_pkg.sv
common/rom_stream_if.sv
verilog/halfword_packer.sv
verilog/rom_fifo.sv
cart_scan/cart_scan.sv
verilog/cart_loader.sv
+incdir+bench
bench/tb_cart_loader.sv

/* run.sh */
#!/bin/sh
# Build and run the cart_loader testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 -Mdir obj_dir --top-module tb_cart_loader -f files.f

status=0
./obj_dir/Vtb_cart_loader > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -eq 0 ] && grep -qx "Test OK" sim.log; then
	echo "Simulation passed"
	exit 0
fi
echo "Simulation did not pass"
exit 1
